//--- verilog/section_pkg.sv
// section buffer shared definitions
`default_nettype none

package section_pkg;

  // frame geometry
  localparam int num_channels = 32;
  localparam int group_size = 8;
  localparam int num_groups = num_channels / group_size;

  localparam int sample_width = 21;
  localparam int limit_width = 20;

  // signed fixed point sample, one per channel
  typedef logic signed [sample_width-1:0] sample_t;

  // unsigned magnitude limit
  typedef logic [limit_width-1:0] limit_t;

  typedef enum logic [1:0] {
    below_neg_limit   = 2'd0,
    negative          = 2'd1,
    below_limit       = 2'd2,
    at_or_above_limit = 2'd3
  } section_code_t;

  // first channel of the group in the top bits
  typedef logic [$bits(section_code_t)*group_size-1:0] section_word_t;

endpackage

`default_nettype wire

//--- verilog/readout_if.sv
// group readout link
`timescale 1ns/1ps
`default_nettype none

interface readout_if #(
  parameter int group_bits = 2,
  parameter int slot_bits = 3,
  parameter type sample_t = logic signed [20:0],
  parameter type word_t = logic [15:0]
);

  logic [group_bits-1:0] group_index;
  logic [slot_bits-1:0] slot_index;
  sample_t sample;
  word_t section_word;

  // indices out, data back within the same cycle
  modport sequencer (
    output group_index,
    output slot_index,
    input  sample,
    input  section_word
  );

  modport frame (
    input  group_index,
    input  slot_index,
    output sample,
    output section_word
  );

endinterface

`default_nettype wire

//--- verilog/section_classifier.sv
// per-channel section classifier
`timescale 1ns/1ps
`default_nettype none

module section_classifier #(
  parameter int num_channels = section_pkg::num_channels,
  parameter int group_size = section_pkg::group_size
) (
  input  section_pkg::sample_t samples [num_channels],
  input  section_pkg::limit_t section_limits [num_channels],
  output section_pkg::section_word_t section_words [num_channels/group_size]
);

  localparam int num_words = num_channels / group_size;
  localparam int code_bits = $bits(section_pkg::section_code_t);
  localparam int ext_width = section_pkg::sample_width + 1;

  // four-way rule on one channel
  function automatic section_pkg::section_code_t classify(
    input section_pkg::sample_t sample,
    input section_pkg::limit_t limit
  );
    logic signed [ext_width-1:0] s_ext;
    logic signed [ext_width-1:0] l_ext;
    section_pkg::section_code_t code;

    // both sides widened so the limit stays positive and its negation fits
    s_ext = ext_width'(sample);
    l_ext = '0;
    l_ext[section_pkg::limit_width-1:0] = limit;

    if (s_ext < -l_ext)
    begin
      code = section_pkg::below_neg_limit;
    end
    else if (s_ext < 0)
    begin
      code = section_pkg::negative;
    end
    else if (s_ext < l_ext)
    begin
      code = section_pkg::below_limit;
    end
    else
    begin
      code = section_pkg::at_or_above_limit;
    end
    return code;
  endfunction

  // pack codes, lowest channel of each group highest
  always_comb
  begin
    for (int w = 0; w < num_words; w++)
    begin
      for (int k = 0; k < group_size; k++)
      begin
        section_words[w][code_bits*(group_size-1-k) +: code_bits] =
          classify(samples[w*group_size + k], section_limits[w*group_size + k]);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/capture_bank.sv
// frame capture register bank
`timescale 1ns/1ps
`default_nettype none

module capture_bank #(
  parameter int depth = 32,
  parameter type payload_t = logic [7:0]
) (
  input  logic clk,
  input  logic reset,
  input  logic write,
  input  payload_t write_data [depth],
  input  logic [$clog2(depth)-1:0] read_index,
  output payload_t read_data
);

  payload_t entries [depth];

  // whole frame captured at once
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < depth; i++)
      begin
        entries[i] <= '0;
      end
    end
    else if (write)
    begin
      for (int i = 0; i < depth; i++)
      begin
        entries[i] <= write_data[i];
      end
    end
  end

  // combinational read port
  assign read_data = entries[read_index];

endmodule

`default_nettype wire

//--- verilog/group_sequencer.sv
// grouped readout sequencer
`timescale 1ns/1ps
`default_nettype none

module group_sequencer #(
  parameter int group_size = section_pkg::group_size,
  parameter int num_groups = section_pkg::num_groups
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic resume,
  readout_if.sequencer readout,
  output section_pkg::sample_t sample_out,
  output logic sample_valid,
  output section_pkg::section_word_t section_select
);

  localparam int slot_bits = $clog2(group_size);
  localparam int group_bits = $clog2(num_groups);
  localparam logic [slot_bits-1:0] last_slot = slot_bits'(group_size - 1);
  localparam logic [group_bits-1:0] last_group = group_bits'(num_groups - 1);

  logic [group_bits-1:0] group_q;
  logic [slot_bits-1:0] slot_q;
  logic armed;
  logic playing;
  logic frame_done;
  logic step;

  // a load cuts the running group short
  assign step = playing && !load;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      group_q <= '0;
      slot_q <= '0;
      armed <= 1'b0;
      playing <= 1'b0;
      // nothing to play until the first load
      frame_done <= 1'b1;
    end
    else if (load)
    begin
      group_q <= '0;
      slot_q <= '0;
      armed <= 1'b1;
      playing <= 1'b0;
      frame_done <= 1'b0;
    end
    else if (armed)
    begin
      armed <= 1'b0;
      playing <= 1'b1;
      slot_q <= '0;
    end
    else if (playing)
    begin
      if (slot_q == last_slot)
      begin
        playing <= 1'b0;
        slot_q <= '0;
        if (group_q == last_group)
        begin
          frame_done <= 1'b1;
        end
        else
        begin
          group_q <= group_q + 1'b1;
        end
      end
      else
      begin
        slot_q <= slot_q + 1'b1;
      end
    end
    else if (resume && !frame_done)
    begin
      // idle here, next group armed
      armed <= 1'b1;
    end
  end

  // registered output stage
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sample_valid <= 1'b0;
      sample_out <= '0;
      section_select <= '0;
    end
    else
    begin
      sample_valid <= step;
      if (step)
      begin
        sample_out <= readout.sample;
        section_select <= readout.section_word;
      end
    end
  end

  assign readout.group_index = group_q;
  assign readout.slot_index = slot_q;

endmodule

`default_nettype wire

//--- verilog/section_buffer_top.sv
// section buffer top level
`timescale 1ns/1ps
`default_nettype none

module section_buffer_top #(
  parameter int num_channels = section_pkg::num_channels,
  parameter int group_size = section_pkg::group_size
) (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic resume,
  input  section_pkg::sample_t samples [num_channels],
  input  section_pkg::limit_t section_limits [num_channels],
  output section_pkg::sample_t sample_out,
  output logic sample_valid,
  output section_pkg::section_word_t section_select
);

  localparam int num_groups = num_channels / group_size;
  localparam int group_bits = $clog2(num_groups);
  localparam int slot_bits = $clog2(group_size);

  // codes from the live port values, captured with the samples
  section_pkg::section_word_t section_words [num_groups];

  readout_if #(
    .group_bits(group_bits),
    .slot_bits(slot_bits),
    .sample_t(section_pkg::sample_t),
    .word_t(section_pkg::section_word_t)
  ) readout ();

  section_classifier #(
    .num_channels(num_channels),
    .group_size(group_size)
  ) classifier (
    .samples(samples),
    .section_limits(section_limits),
    .section_words(section_words)
  );

  // frame side of the readout link
  capture_bank #(
    .depth(num_channels),
    .payload_t(section_pkg::sample_t)
  ) sample_bank (
    .clk(clk),
    .reset(reset),
    .write(load),
    .write_data(samples),
    .read_index({readout.group_index, readout.slot_index}),
    .read_data(readout.sample)
  );

  capture_bank #(
    .depth(num_groups),
    .payload_t(section_pkg::section_word_t)
  ) section_bank (
    .clk(clk),
    .reset(reset),
    .write(load),
    .write_data(section_words),
    .read_index(readout.group_index),
    .read_data(readout.section_word)
  );

  group_sequencer #(
    .group_size(group_size),
    .num_groups(num_groups)
  ) sequencer (
    .clk(clk),
    .reset(reset),
    .load(load),
    .resume(resume),
    .readout(readout.sequencer),
    .sample_out(sample_out),
    .sample_valid(sample_valid),
    .section_select(section_select)
  );

endmodule

`default_nettype wire

//--- verif/tb_tasks.svh
// section buffer directed tests

task automatic randomize_frame();
  logic [31:0] r;
  for (int i = 0; i < num_channels; i++)
  begin
    r = next_random();
    samples_drv[i] = r[20:0];
    r = next_random();
    limits_drv[i] = r[19:0];
  end
endtask

task automatic reset_and_idle();
  start_case("reset and idle");
  if (sample_valid || sample_out != 0 || section_select != 0)
    report_mismatch("outputs not cleared after reset");
  // reset in the middle of a group clears everything again
  randomize_frame();
  pulse_load();
  wait_for_valid(2, "first load");
  compare_group(0, 3, 8'h00);
  apply_reset();
  if (sample_valid || sample_out != 0 || section_select != 0)
    report_mismatch("outputs not cleared by reset during playback");
  pulse_resume();
  watch_quiet(12, "resume without load");
  finish_case();
endtask

task automatic fixed_frame_group0();
  logic [31:0] v;
  start_case("fixed frame group 0");
  for (int i = 0; i < num_channels; i++)
  begin
    v = i * 4093 - 60000;
    samples_drv[i] = v[20:0];
    limits_drv[i] = 20'd1000;
  end
  // edges at minus and plus the limit
  samples_drv[0] = -21'sd1001;
  samples_drv[1] = -21'sd1000;
  samples_drv[2] = -21'sd1;
  samples_drv[3] = 21'sd0;
  samples_drv[4] = 21'sd999;
  samples_drv[5] = 21'sd1000;
  samples_drv[6] = 21'sd1001;
  // most negative sample
  samples_drv[7] = 21'h10_0000;
  pulse_load();
  if (exp_words[0] != 16'h16bc)
    report_mismatch($sformatf("predicted group 0 word %h, expected 16bc", exp_words[0]));
  wait_for_valid(2, "fixed load");
  compare_group(0, group_size, 8'h00);
  finish_case();
endtask

task automatic resumes_through_frame();
  start_case("resumes through frame");
  for (int f = 0; f < 2; f++)
  begin
    randomize_frame();
    pulse_load();
    // new port values must not reach the captured frame
    randomize_frame();
    wait_for_valid(2, "random load");
    compare_group(0, group_size, 8'h00);
    for (int g = 1; g < num_groups; g++)
    begin
      pulse_resume();
      wait_for_valid(2, $sformatf("resume to group %0d", g));
      compare_group(g, group_size, 8'h00);
    end
    pulse_resume();
    watch_quiet(12, "resume after group 3");
  end
  finish_case();
endtask

task automatic resume_during_group();
  start_case("resume during group");
  randomize_frame();
  pulse_load();
  // lands while playback is only armed
  pulse_resume();
  wait_for_valid(1, "load with early resume");
  compare_group(0, group_size, 8'b0100_0101);
  watch_quiet(12, "after ignored resumes");
  pulse_resume();
  wait_for_valid(2, "resume to group 1");
  compare_group(1, group_size, 8'h00);
  finish_case();
endtask

task automatic reload_mid_group();
  start_case("reload mid group");
  randomize_frame();
  pulse_load();
  wait_for_valid(2, "first frame");
  compare_group(0, 3, 8'h00);
  randomize_frame();
  pulse_load();
  wait_for_valid(2, "reload");
  compare_group(0, group_size, 8'h00);
  pulse_resume();
  wait_for_valid(2, "resume after reload");
  compare_group(1, group_size, 8'h00);
  finish_case();
endtask

//--- verif/tb_section_buffer.sv
// section buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_section_buffer;

  localparam int num_channels = section_pkg::num_channels;
  localparam int group_size = section_pkg::group_size;
  localparam int num_groups = section_pkg::num_groups;
  localparam int wait_limit = 20;

  logic clk;
  logic reset;
  logic load;
  logic resume;
  section_pkg::sample_t samples_drv [num_channels];
  section_pkg::limit_t limits_drv [num_channels];
  section_pkg::sample_t sample_out;
  logic sample_valid;
  section_pkg::section_word_t section_select;

  // frame as captured at the last load
  section_pkg::sample_t exp_samples [num_channels];
  section_pkg::limit_t exp_limits [num_channels];
  section_pkg::section_word_t exp_words [num_groups];

  logic [31:0] rng_state;
  int errors;
  int tests_run;
  int tests_failed;
  int case_start_errors;
  string case_name;

  section_buffer_top UUT (
    .clk(clk),
    .reset(reset),
    .load(load),
    .resume(resume),
    .samples(samples_drv),
    .section_limits(limits_drv),
    .sample_out(sample_out),
    .sample_valid(sample_valid),
    .section_select(section_select)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // section rule on plain integers
  function automatic section_pkg::section_code_t ref_code(
    input section_pkg::sample_t sample,
    input section_pkg::limit_t limit
  );
    int s;
    int l;
    s = int'(sample);
    l = int'(limit);
    if (s < -l)
      return section_pkg::below_neg_limit;
    if (s < 0)
      return section_pkg::negative;
    if (s < l)
      return section_pkg::below_limit;
    return section_pkg::at_or_above_limit;
  endfunction

  // first channel of the group ends up in the top bits
  function automatic section_pkg::section_word_t ref_word(input int g);
    section_pkg::section_word_t word;
    word = '0;
    for (int k = 0; k < group_size; k++)
    begin
      word = (word << 2) | section_pkg::section_word_t'(
        ref_code(exp_samples[g*group_size + k], exp_limits[g*group_size + k]));
    end
    return word;
  endfunction

  task automatic apply_reset();
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic start_case(input string name);
    case_name = name;
    case_start_errors = errors;
  endtask

  task automatic finish_case();
    tests_run++;
    if (errors == case_start_errors)
    begin
      $display("%s: pass", case_name);
    end
    else
    begin
      tests_failed++;
      $display("%s: fail, %0d errors", case_name, errors - case_start_errors);
    end
  endtask

  // all tasks start and end right after a falling edge
  task automatic pulse_load();
    load = 1'b1;
    for (int i = 0; i < num_channels; i++)
    begin
      exp_samples[i] = samples_drv[i];
      exp_limits[i] = limits_drv[i];
    end
    for (int g = 0; g < num_groups; g++)
    begin
      exp_words[g] = ref_word(g);
    end
    @(negedge clk);
    load = 1'b0;
  endtask

  task automatic pulse_resume();
    resume = 1'b1;
    @(negedge clk);
    resume = 1'b0;
  endtask

  task automatic wait_for_valid(input int expect_cycles, input string where);
    int cycles;
    cycles = 0;
    while (!sample_valid && cycles < wait_limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!sample_valid)
    begin
      report_failure($sformatf("timeout: sample_valid never rose in %s", where));
    end
    else if (cycles != expect_cycles)
    begin
      report_mismatch($sformatf("%s: valid after %0d cycles, expected %0d",
                                where, cycles, expect_cycles));
    end
  endtask

  // checks count samples of group g; resume is raised after each slot set in poke_mask
  task automatic compare_group(input int g, input int count, input logic [7:0] poke_mask);
    for (int k = 0; k < count; k++)
    begin
      if (!sample_valid)
        report_mismatch($sformatf("group %0d slot %0d: sample_valid low", g, k));
      if (sample_out != exp_samples[g*group_size + k])
        report_mismatch($sformatf("group %0d slot %0d: sample %0d, expected %0d",
                                  g, k, sample_out, exp_samples[g*group_size + k]));
      if (section_select != exp_words[g])
        report_mismatch($sformatf("group %0d slot %0d: section word %h, expected %h",
                                  g, k, section_select, exp_words[g]));
      resume = poke_mask[k];
      @(negedge clk);
    end
    resume = 1'b0;
    if (count == group_size && sample_valid)
      report_mismatch($sformatf("group %0d: sample_valid still high after 8 samples", g));
    if (count == group_size && section_select != exp_words[g])
      report_mismatch($sformatf("group %0d: section word not held after the group", g));
  endtask

  task automatic watch_quiet(input int cycles, input string where);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      if (sample_valid && !seen)
      begin
        report_mismatch($sformatf("%s: unexpected valid output", where));
        seen = 1'b1;
      end
    end
  endtask

  `include "tb_tasks.svh"

  initial
  begin
    rng_state = 32'd85;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    load = 1'b0;
    resume = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < num_channels; i++)
    begin
      samples_drv[i] = '0;
      limits_drv[i] = '0;
    end
    apply_reset();

    reset_and_idle();
    fixed_frame_group0();
    resumes_through_frame();
    resume_during_group();
    reload_mid_group();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/section_pkg.sv
verilog/readout_if.sv
verilog/section_classifier.sv
verilog/capture_bank.sv
verilog/group_sequencer.sv
verilog/section_buffer_top.sv
+incdir+verif
verif/tb_section_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the section buffer simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_section_buffer \
  -f list.f \
  -o tb_section_buffer
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

output=$(./obj_dir/tb_section_buffer 2>&1)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
